//--- logic/periph_addr_decoder.sv
// Address decoder of the peripheral crossbar
// Maps each initiator request onto one bit of the request matrix
// and returns the matching grant from the target arbiters

`timescale 1ns/1ns

module periph_addr_decoder (
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                  req_i,
  input  periph_xbar_pkg::addr_t [periph_xbar_pkg::NUM_INITIATORS-1:0] addr_i,
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]
               [periph_xbar_pkg::NUM_TARGETS-1:0]                     arb_gnt_i,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]
               [periph_xbar_pkg::NUM_TARGETS-1:0]                     arb_req_o,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                  gnt_o
);

  // Selected target per initiator
  periph_xbar_pkg::tgt_idx_t [periph_xbar_pkg::NUM_INITIATORS-1:0] tgt_sel;

  // Cluster peripheral accesses use the routing field, the rest go external
  function automatic periph_xbar_pkg::tgt_idx_t addr_to_target(
    input periph_xbar_pkg::addr_t addr
  );
    logic cluster_hit;
    logic alias_hit;
    logic region_hit;

    alias_hit   = periph_xbar_pkg::CLUSTER_ALIAS_EN &&
                  (addr[31:24] == periph_xbar_pkg::CLUSTER_ALIAS_BASE);
    cluster_hit = (addr[31:24] == periph_xbar_pkg::CLUSTER_BASE) || alias_hit;
    region_hit  = (addr[23:20] >= periph_xbar_pkg::PERIPH_REGION_LO) &&
                  (addr[23:20] <= periph_xbar_pkg::PERIPH_REGION_HI);

    if (cluster_hit && region_hit) begin
      return addr[periph_xbar_pkg::ROUTING_LSB +: $bits(periph_xbar_pkg::tgt_idx_t)];
    end else begin
      return periph_xbar_pkg::EXT_TARGET;
    end
  endfunction

  for (genvar i = 0; i < periph_xbar_pkg::NUM_INITIATORS; i++) begin : gen_init_decode

    assign tgt_sel[i] = addr_to_target(addr_i[i]);

    // One request bit raised, on the selected target column
    always_comb begin
      arb_req_o[i] = '0;
      arb_req_o[i][tgt_sel[i]] = req_i[i];
    end

    // Grant comes only from the arbiter this initiator asked
    assign gnt_o[i] = arb_gnt_i[i][tgt_sel[i]];

  end

endmodule

//--- logic/periph_resp_router.sv
// Response router of the peripheral crossbar
// Steers each target response to the initiator named by its one-hot id,
// lowest target index first when two targets answer the same initiator

`timescale 1ns/1ns

module periph_resp_router (
  input  logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_r_valid_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_TARGETS-1:0]    tgt_r_rdata_i,
  input  periph_xbar_pkg::init_id_t [periph_xbar_pkg::NUM_TARGETS-1:0] tgt_r_id_i,
  input  logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_r_opc_i,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   r_valid_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_INITIATORS-1:0] r_rdata_o,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   r_opc_o
);

  localparam int unsigned NUM_TGT = periph_xbar_pkg::NUM_TARGETS;

  for (genvar i = 0; i < periph_xbar_pkg::NUM_INITIATORS; i++) begin : gen_init_resp

    // Targets currently answering this initiator
    logic [NUM_TGT-1:0] hit;

    for (genvar t = 0; t < NUM_TGT; t++) begin : gen_hit
      assign hit[t] = tgt_r_valid_i[t] && tgt_r_id_i[t][i];
    end

    // First hit from target 0 upward, outputs stay zero without one
    always_comb begin
      r_valid_o[i] = 1'b0;
      r_rdata_o[i] = '0;
      r_opc_o[i]   = 1'b0;
      for (int t = 0; t < NUM_TGT; t++) begin
        if (hit[t] && !r_valid_o[i]) begin
          r_valid_o[i] = 1'b1;
          r_rdata_o[i] = tgt_r_rdata_i[t];
          r_opc_o[i]   = tgt_r_opc_i[t];
        end
      end
    end

  end

endmodule

//--- logic/periph_rr_arbiter.sv
// Round-robin arbiter for one peripheral target
// Picks a winner from the priority pointer, forwards its fields and id,
// grants it when the target accepts and then moves the pointer past it

`timescale 1ns/1ns

module periph_rr_arbiter (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   req_i,
  input  periph_xbar_pkg::addr_t [periph_xbar_pkg::NUM_INITIATORS-1:0] addr_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_INITIATORS-1:0] wdata_i,
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   wen_i,
  input  periph_xbar_pkg::be_t   [periph_xbar_pkg::NUM_INITIATORS-1:0] be_i,
  input  logic                                                         tgt_gnt_i,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   gnt_o,
  output logic                                                         tgt_req_o,
  output periph_xbar_pkg::addr_t                                       tgt_addr_o,
  output periph_xbar_pkg::data_t                                       tgt_wdata_o,
  output logic                                                         tgt_wen_o,
  output periph_xbar_pkg::be_t                                         tgt_be_o,
  output periph_xbar_pkg::init_id_t                                    tgt_id_o
);

  localparam int unsigned NUM_INIT = periph_xbar_pkg::NUM_INITIATORS;

  typedef logic [$clog2(NUM_INIT)-1:0] init_idx_t;

  // Highest priority initiator for the next decision
  init_idx_t ptr_q;
  init_idx_t win_idx;
  logic      win_found;
  logic      transfer;

  // Search starts at the pointer and wraps around
  always_comb begin
    int cand;

    win_found = 1'b0;
    win_idx   = '0;
    for (int off = 0; off < NUM_INIT; off++) begin
      cand = (int'(ptr_q) + off) % NUM_INIT;
      if (!win_found && req_i[cand]) begin
        win_found = 1'b1;
        win_idx   = init_idx_t'(cand);
      end
    end
  end

  // Winner fields go straight to the target
  assign tgt_req_o   = win_found;
  assign tgt_addr_o  = addr_i[win_idx];
  assign tgt_wdata_o = wdata_i[win_idx];
  assign tgt_wen_o   = wen_i[win_idx];
  assign tgt_be_o    = be_i[win_idx];
  assign tgt_id_o    = win_found ? (periph_xbar_pkg::init_id_t'(1) << win_idx) : '0;

  // Target acceptance completes the transfer
  assign transfer = win_found && tgt_gnt_i;
  assign gnt_o    = transfer ? tgt_id_o : '0;

  // Pointer moves only on a completed transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (transfer) begin
      if (win_idx == init_idx_t'(NUM_INIT - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + init_idx_t'(1);
      end
    end
  end

endmodule

//--- logic/periph_xbar_pkg.sv
// Shared sizes, address map and types of the peripheral crossbar
// Five initiators (four cores, one master peripheral port) to four targets

package periph_xbar_pkg;

  // Port counts
  localparam int unsigned NUM_INITIATORS = 5;
  localparam int unsigned NUM_TARGETS    = 4;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Payload types
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

  // Target index, one bit per initiator for the id
  typedef logic [$clog2(NUM_TARGETS)-1:0] tgt_idx_t;
  typedef logic [NUM_INITIATORS-1:0]      init_id_t;

  // Cluster identification in address bits 31:24
  localparam logic [7:0] CLUSTER_BASE       = 8'h10;
  localparam bit         CLUSTER_ALIAS_EN   = 1'b1;
  localparam logic [7:0] CLUSTER_ALIAS_BASE = 8'h1B;

  // Peripheral region in address bits 23:20, bounds inclusive
  localparam logic [3:0] PERIPH_REGION_LO = 4'h2;
  localparam logic [3:0] PERIPH_REGION_HI = 4'h3;

  // Target select field starts here, width given by tgt_idx_t
  localparam int unsigned ROUTING_LSB = 16;

  // Everything outside the cluster peripherals
  localparam tgt_idx_t EXT_TARGET = 2'd3;

endpackage

//--- logic/periph_xbar_top.sv
// Top level of the peripheral crossbar
// Address decoder, one round-robin arbiter per target and the response router

`timescale 1ns/1ns

module periph_xbar_top (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  // Initiator request side
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   req_i,
  input  periph_xbar_pkg::addr_t [periph_xbar_pkg::NUM_INITIATORS-1:0] addr_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_INITIATORS-1:0] wdata_i,
  input  logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   wen_i,
  input  periph_xbar_pkg::be_t   [periph_xbar_pkg::NUM_INITIATORS-1:0] be_i,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   gnt_o,
  // Initiator response side
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   r_valid_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_INITIATORS-1:0] r_rdata_o,
  output logic [periph_xbar_pkg::NUM_INITIATORS-1:0]                   r_opc_o,
  // Target request side
  output logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_req_o,
  output periph_xbar_pkg::addr_t [periph_xbar_pkg::NUM_TARGETS-1:0]    tgt_addr_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_TARGETS-1:0]    tgt_wdata_o,
  output logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_wen_o,
  output periph_xbar_pkg::be_t   [periph_xbar_pkg::NUM_TARGETS-1:0]    tgt_be_o,
  output periph_xbar_pkg::init_id_t [periph_xbar_pkg::NUM_TARGETS-1:0] tgt_id_o,
  input  logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_gnt_i,
  // Target response side
  input  logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_r_valid_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NUM_TARGETS-1:0]    tgt_r_rdata_i,
  input  periph_xbar_pkg::init_id_t [periph_xbar_pkg::NUM_TARGETS-1:0] tgt_r_id_i,
  input  logic [periph_xbar_pkg::NUM_TARGETS-1:0]                      tgt_r_opc_i
);

  localparam int unsigned NUM_INIT = periph_xbar_pkg::NUM_INITIATORS;
  localparam int unsigned NUM_TGT  = periph_xbar_pkg::NUM_TARGETS;

  // Request and grant matrices, initiator by target
  logic [NUM_INIT-1:0][NUM_TGT-1:0] arb_req;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] arb_gnt;

  periph_addr_decoder i_addr_decoder (
    .req_i     (req_i),
    .addr_i    (addr_i),
    .arb_gnt_i (arb_gnt),
    .arb_req_o (arb_req),
    .gnt_o     (gnt_o)
  );

  // One arbiter per target, each sees its own matrix column
  for (genvar k = 0; k < NUM_TGT; k++) begin : gen_tgt_arb

    logic [NUM_INIT-1:0] col_req;
    logic [NUM_INIT-1:0] col_gnt;

    for (genvar j = 0; j < NUM_INIT; j++) begin : gen_col
      assign col_req[j]    = arb_req[j][k];
      assign arb_gnt[j][k] = col_gnt[j];
    end

    periph_rr_arbiter i_rr_arbiter (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (col_req),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wen_i       (wen_i),
      .be_i        (be_i),
      .tgt_gnt_i   (tgt_gnt_i[k]),
      .gnt_o       (col_gnt),
      .tgt_req_o   (tgt_req_o[k]),
      .tgt_addr_o  (tgt_addr_o[k]),
      .tgt_wdata_o (tgt_wdata_o[k]),
      .tgt_wen_o   (tgt_wen_o[k]),
      .tgt_be_o    (tgt_be_o[k]),
      .tgt_id_o    (tgt_id_o[k])
    );

  end

  periph_resp_router i_resp_router (
    .tgt_r_valid_i (tgt_r_valid_i),
    .tgt_r_rdata_i (tgt_r_rdata_i),
    .tgt_r_id_i    (tgt_r_id_i),
    .tgt_r_opc_i   (tgt_r_opc_i),
    .r_valid_o     (r_valid_o),
    .r_rdata_o     (r_rdata_o),
    .r_opc_o       (r_opc_o)
  );

endmodule

//--- periph_xbar.f
logic/periph_xbar_pkg.sv
logic/periph_addr_decoder.sv
logic/periph_rr_arbiter.sv
logic/periph_resp_router.sv
logic/periph_xbar_top.sv
test/periph_xbar_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"

verilator --binary --timing -Wall --top-module periph_xbar_tb \
  -f periph_xbar.f --Mdir "$OBJ" -o periph_xbar_sim

"./$OBJ/periph_xbar_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Failure found in $LOG"
  exit 1
fi

if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No result line in $LOG"
  exit 1
fi

exit 0

//--- test/periph_xbar_tb.sv
// Testbench of the peripheral crossbar
// Target models, reference decode and round-robin model, stimulus and checks

`timescale 1ns/1ns

module periph_xbar_tb;

  localparam int NI = periph_xbar_pkg::NUM_INITIATORS;
  localparam int NT = periph_xbar_pkg::NUM_TARGETS;
  localparam int MAX_CYCLES = 3000;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [NI-1:0] req = '0;
  periph_xbar_pkg::addr_t [NI-1:0] addr = '0;
  periph_xbar_pkg::data_t [NI-1:0] wdata = '0;
  logic [NI-1:0] wen = '1;
  periph_xbar_pkg::be_t [NI-1:0] be = '0;
  logic [NI-1:0] gnt;
  logic [NI-1:0] r_valid;
  periph_xbar_pkg::data_t [NI-1:0] r_rdata;
  logic [NI-1:0] r_opc;
  logic [NT-1:0] tgt_req;
  periph_xbar_pkg::addr_t [NT-1:0] tgt_addr;
  periph_xbar_pkg::data_t [NT-1:0] tgt_wdata;
  logic [NT-1:0] tgt_wen;
  periph_xbar_pkg::be_t [NT-1:0] tgt_be;
  periph_xbar_pkg::init_id_t [NT-1:0] tgt_id;
  logic [NT-1:0] tgt_gnt = '1;
  logic [NT-1:0] tgt_r_valid = '0;
  periph_xbar_pkg::data_t [NT-1:0] tgt_r_rdata = '0;
  periph_xbar_pkg::init_id_t [NT-1:0] tgt_r_id = '0;
  logic [NT-1:0] tgt_r_opc = '0;

  string test_name = "reset";
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int ref_ptr [NT];
  logic [NI-1:0] exp_rv = '0;
  logic [31:0] exp_rdata [NI];

  periph_xbar_top uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .wen_i         (wen),
    .be_i          (be),
    .gnt_o         (gnt),
    .r_valid_o     (r_valid),
    .r_rdata_o     (r_rdata),
    .r_opc_o       (r_opc),
    .tgt_req_o     (tgt_req),
    .tgt_addr_o    (tgt_addr),
    .tgt_wdata_o   (tgt_wdata),
    .tgt_wen_o     (tgt_wen),
    .tgt_be_o      (tgt_be),
    .tgt_id_o      (tgt_id),
    .tgt_gnt_i     (tgt_gnt),
    .tgt_r_valid_i (tgt_r_valid),
    .tgt_r_rdata_i (tgt_r_rdata),
    .tgt_r_id_i    (tgt_r_id),
    .tgt_r_opc_i   (tgt_r_opc)
  );

  always #4 clk = ~clk;

  // Decode rule of the address map
  function automatic int addr_target(input logic [31:0] a);
    logic in_cluster;
    logic in_region;
    in_cluster = (a[31:24] == 8'h10) || (a[31:24] == 8'h1B);
    in_region  = (a[23:20] >= 4'h2) && (a[23:20] <= 4'h3);
    return (in_cluster && in_region) ? int'(a[17:16]) : 3;
  endfunction

  function automatic logic [31:0] make_addr(input logic [7:0] top, input logic [3:0] region,
                                            input logic [1:0] route);
    logic [31:0] r;
    r = $urandom;
    return {top, region, r[3:2], route, r[31:16]};
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED test=%s %s expected=%h actual=%h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // Targets accept per tgt_gnt and answer one cycle after a transfer
  always @(posedge clk) begin
    for (int k = 0; k < NT; k++) begin
      tgt_r_valid[k] <= rst_n && tgt_req[k] && tgt_gnt[k];
      tgt_r_id[k]    <= tgt_id[k];
      tgt_r_rdata[k] <= tgt_addr[k] ^ 32'(k);
    end
  end

  // Reference model of arbitration and routing, compared every cycle
  always @(posedge clk) begin
    logic [NI-1:0] exp_gnt;
    logic [NI-1:0] col;
    logic [NI-1:0] next_rv;
    int w;
    exp_gnt = '0;
    next_rv = '0;
    if (!rst_n) begin
      for (int k = 0; k < NT; k++) begin
        ref_ptr[k] = 0;
      end
    end else begin
      for (int i = 0; i < NI; i++) begin
        check_val($sformatf("r_valid[%0d]", i), 32'(exp_rv[i]), 32'(r_valid[i]));
        if (exp_rv[i]) begin
          check_val($sformatf("r_rdata[%0d]", i), exp_rdata[i], r_rdata[i]);
        end
        check_val($sformatf("r_opc[%0d]", i), 32'd0, 32'(r_opc[i]));
      end
      for (int k = 0; k < NT; k++) begin
        for (int i = 0; i < NI; i++) begin
          col[i] = req[i] && (addr_target(addr[i]) == k);
        end
        check_val($sformatf("tgt_req[%0d]", k), 32'(|col), 32'(tgt_req[k]));
        if (|col) begin
          w = -1;
          for (int off = 0; off < NI; off++) begin
            if (w < 0 && col[(ref_ptr[k] + off) % NI]) begin
              w = (ref_ptr[k] + off) % NI;
            end
          end
          check_val($sformatf("tgt_id[%0d]", k), 32'(1 << w), 32'(tgt_id[k]));
          check_val($sformatf("tgt_addr[%0d]", k), addr[w], tgt_addr[k]);
          check_val($sformatf("tgt_wdata[%0d]", k), wdata[w], tgt_wdata[k]);
          check_val($sformatf("tgt_wen[%0d]", k), 32'(wen[w]), 32'(tgt_wen[k]));
          check_val($sformatf("tgt_be[%0d]", k), 32'(be[w]), 32'(tgt_be[k]));
          if (tgt_gnt[k]) begin
            exp_gnt[w]   = 1'b1;
            next_rv[w]   = 1'b1;
            exp_rdata[w] = addr[w] ^ 32'(k);
            ref_ptr[k]   = (w + 1) % NI;
          end
        end
      end
      check_val("gnt", 32'(exp_gnt), 32'(gnt));
    end
    exp_rv <= next_rv;
  end

  // Run length limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a test did not finish", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Hold requests of the initiators in mask until each is granted
  task automatic wait_grants(input logic [NI-1:0] mask);
    logic [NI-1:0] pending;
    logic [NI-1:0] got;
    pending = mask;
    while (pending != '0) begin
      @(posedge clk);
      got = pending & gnt;
      pending = pending & ~gnt;
      @(negedge clk);
      req = req & ~got;
    end
  endtask

  task automatic set_fields(input int i, input logic [31:0] a);
    addr[i]  = a;
    wdata[i] = $urandom;
    wen[i]   = 1'($urandom % 2);
    be[i]    = 4'($urandom % 16);
  endtask

  initial begin
    int rr_count;
    int idx;
    int n;
    logic [31:0] held_addr;
    void'($urandom(24450));
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    // All initiators compete for target 1, grants rotate from 0
    test_name = "round_robin";
    for (int i = 0; i < NI; i++) begin
      set_fields(i, make_addr(8'h10, 4'h2, 2'd1));
    end
    req = '1;
    rr_count = 0;
    while (rr_count < 15) begin
      @(posedge clk);
      if (gnt != '0) begin
        idx = $clog2(gnt);
        check_val("grant order", 32'(rr_count % NI), 32'(idx));
        rr_count++;
      end
    end
    @(negedge clk);
    req = '0;
    repeat (2) @(negedge clk);

    // Target 2 stalls, then accepts initiator 1 first
    test_name = "back_pressure";
    tgt_gnt[2] = 1'b0;
    set_fields(1, make_addr(8'h10, 4'h3, 2'd2));
    set_fields(3, make_addr(8'h1B, 4'h2, 2'd2));
    req = 5'b01010;
    held_addr = addr[1];
    repeat (5) begin
      @(posedge clk);
      check_val("stalled gnt", 32'd0, 32'(gnt));
      check_val("stalled tgt_req", 32'd1, 32'(tgt_req[2]));
      check_val("stalled tgt_addr", held_addr, tgt_addr[2]);
    end
    @(negedge clk);
    tgt_gnt[2] = 1'b1;
    @(posedge clk);
    check_val("first after stall", 32'b00010, 32'(gnt));
    @(negedge clk);
    req[1] = 1'b0;
    wait_grants(5'b01000);
    repeat (2) @(negedge clk);

    // Random single requests over all decode cases
    test_name = "address_decode";
    for (n = 0; n < 80; n++) begin
      idx = $urandom % NI;
      case (n % 4)
        0: set_fields(idx, make_addr(8'h10, 4'h2 + 4'($urandom % 2), 2'($urandom)));
        1: set_fields(idx, make_addr(8'h1B, 4'h2 + 4'($urandom % 2), 2'($urandom)));
        2: set_fields(idx, make_addr(8'h10, 4'h4 + 4'($urandom % 12), 2'($urandom)));
        default: set_fields(idx, make_addr(8'h20 + 8'($urandom % 64), 4'h2, 2'($urandom)));
      endcase
      req[idx] = 1'b1;
      wait_grants(5'(1 << idx));
      @(negedge clk);
    end

    // Four initiators on four targets in one cycle
    test_name = "parallel";
    for (int i = 0; i < NT; i++) begin
      set_fields(i, make_addr(8'h10, 4'h2, 2'(i)));
    end
    req = 5'b01111;
    @(posedge clk);
    check_val("parallel gnt", 32'b01111, 32'(gnt));
    @(negedge clk);
    req = '0;
    repeat (4) @(negedge clk);

    $display("Run finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
